/* logic/board_bus_consts.svh */
// ----------------------------------------------------------------------
// board bus constants for address spaces, channel 0 register offsets,
// real-time block layout and watchdog timing
// ----------------------------------------------------------------------
`ifndef BOARD_BUS_CONSTS_SVH
`define BOARD_BUS_CONSTS_SVH

// ----------------------------------------------------------------------
// address spaces in bits 15:12 of a bus address
// ----------------------------------------------------------------------
`define ADDR_MAIN       4'h0    // board registers and per-channel registers
`define ADDR_HUB        4'h1    // hub memory holding quadlets from other boards
// any other space code falls through to the external board

// ----------------------------------------------------------------------
// channel 0 board registers with the offset in bits 3:0
// ----------------------------------------------------------------------
`define REG_STATUS      4'd0    // board id, watchdog flag, period low half
`define REG_TIMESTAMP   4'd1    // free-running timestamp from the board
`define REG_WDOG        4'd3    // watchdog period in ticks where 0 disables it

// first per-channel offset used by the real-time block
`define RT_MOTOR_REG0   4'd0    // 2 quadlets per motor channel
`define RT_ENC_REG0     4'd5    // 5 quadlets per encoder channel

// default channel counts
`define NUM_MOTORS      4
`define NUM_ENCODERS    4

// sysclk cycles per watchdog count
// kept short so the timeout shows up quickly in simulation
`define WDOG_TICK       4

`endif

/* logic/board_bus_pkg.sv */
// ----------------------------------------------------------------------
// board bus types for the 16-bit register address seen through its two
// decodings and the 32-bit data quadlet
// ----------------------------------------------------------------------
package board_bus_pkg;

    // one data quadlet on the read or write bus
    typedef logic [31:0] quad_t;

    // main space view of a board or channel register
    typedef struct packed {
        logic [3:0] space;      // address space code
        logic [3:0] rsvd;       // not decoded here
        logic [3:0] chan;       // 0 = board registers, 1..n = channels
        logic [3:0] offset;     // register within the channel
    } main_addr_t;

    // hub space view of a quadlet from another board
    typedef struct packed {
        logic [3:0] space;      // address space code
        logic [3:0] rsvd;       // not decoded here
        logic [3:0] board;      // source board number
        logic [3:0] quad;       // quadlet index within that board
    } hub_addr_t;

    // same 16 bits decoded by space
    // space picks which view is meaningful and the rest of the word
    // is read through that view
    typedef union packed {
        main_addr_t main;
        hub_addr_t  hub;
    } reg_addr_t;

endpackage

/* logic/reg_bus_if.sv */
// ----------------------------------------------------------------------
// register bus between the top level and one target block
// ----------------------------------------------------------------------
`timescale 1ns/10ps

interface reg_bus_if;
    import board_bus_pkg::*;

    reg_addr_t raddr;   // read address held by the master until data valid
    quad_t     rdata;   // read data from the target
    logic      rwait;   // 1 = target needs an extra cycle for read data
    reg_addr_t waddr;   // write address
    quad_t     wdata;   // write data
    logic      wen;     // single-cycle write strobe

    // top level side
    modport host (
        output raddr, waddr, wdata, wen,
        input  rdata, rwait
    );

    // target block side
    modport target (
        input  raddr, waddr, wdata, wen,
        output rdata, rwait
    );

endinterface

/* logic/read_addr_translate.sv */
// ----------------------------------------------------------------------
// read address translation for the real-time block read that maps a
// quadlet index onto the board and channel register it reports
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "board_bus_consts.svh"

module read_addr_translate #(
    parameter int NUM_MOTORS   = `NUM_MOTORS,
    parameter int NUM_ENCODERS = `NUM_ENCODERS
) (
    input  board_bus_pkg::reg_addr_t reg_raddr_in,
    input  logic                     blk_rt_rd,
    output board_bus_pkg::reg_addr_t reg_raddr_out
);

    // quadlet ranges inside the block
    localparam int MOT_Q0 = 2;                          // after status and timestamp
    localparam int MOT_QN = MOT_Q0 + 2 * NUM_MOTORS;    // first encoder quadlet
    localparam int ENC_QN = MOT_QN + 5 * NUM_ENCODERS;  // end of the table

    logic [7:0] q;      // quadlet index from the master
    logic [7:0] idx;    // index within the motor or encoder range

    assign q = {reg_raddr_in.main.chan, reg_raddr_in.main.offset};

    always_comb begin
        reg_raddr_out = reg_raddr_in;                   // normal reads pass through
        idx = 8'd0;
        if (blk_rt_rd && (q < 8'(ENC_QN))) begin
            reg_raddr_out = '0;
            reg_raddr_out.main.space = `ADDR_MAIN;
            if (q == 8'd0) begin
                reg_raddr_out.main.offset = `REG_STATUS;     // channel 0
            end else if (q == 8'd1) begin
                reg_raddr_out.main.offset = `REG_TIMESTAMP;  // channel 0
            end else if (q < 8'(MOT_QN)) begin
                idx = q - 8'(MOT_Q0);
                reg_raddr_out.main.chan   = 4'(idx >> 1) + 4'd1;        // motor m+1
                reg_raddr_out.main.offset = `RT_MOTOR_REG0 + {3'd0, idx[0]};
            end else begin
                idx = q - 8'(MOT_QN);
                reg_raddr_out.main.chan   = 4'(idx / 8'd5) + 4'd1;      // encoder e+1
                reg_raddr_out.main.offset = `RT_ENC_REG0 + 4'(idx % 8'd5);
            end
        end
        // quadlets past the table keep the raw address
    end

endmodule

/* logic/hub_mem.sv */
// ----------------------------------------------------------------------
// hub memory of 16 boards by 16 quadlets that is written from the bus
// and read back with one registered address stage
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "board_bus_consts.svh"

module hub_mem (
    input  logic       sysclk,
    input  logic       reset,
    reg_bus_if.target  bus
);
    import board_bus_pkg::*;

    quad_t      mem [16][16];   // [board][quad]
    logic [3:0] rd_board;       // registered read address
    logic [3:0] rd_quad;
    logic       hub_wr;         // write aimed at the hub space

    assign hub_wr = bus.wen && (bus.waddr.hub.space == `ADDR_HUB);

    // ------------------------------------------------------------------
    // write side
    // ------------------------------------------------------------------

    // quadlet from the bus lands at its board and quad index
    always_ff @(posedge sysclk) begin
        if (hub_wr) begin
            mem[bus.waddr.hub.board][bus.waddr.hub.quad] <= bus.wdata;
        end
    end

    // ------------------------------------------------------------------
    // read side
    // ------------------------------------------------------------------

    // first read cycle with the top level register adding the second
    always_ff @(posedge sysclk) begin
        if (reset) begin
            rd_board <= 4'd0;
            rd_quad  <= 4'd0;
        end else begin
            rd_board <= bus.raddr.hub.board;
            rd_quad  <= bus.raddr.hub.quad;
        end
    end

    assign bus.rdata = mem[rd_board][rd_quad];    // word for last cycle's address

    // memory reads always take two sysclks at the top level
    assign bus.rwait = 1'b1;

endmodule

/* logic/board_regs.sv */
// ----------------------------------------------------------------------
// channel 0 board registers for status, timestamp and the watchdog with
// its period, tick prescaler and timeout flag
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "board_bus_consts.svh"

module board_regs (
    input  logic                 sysclk,
    input  logic                 reset,
    input  logic [3:0]           board_id,      // rotary switch
    input  board_bus_pkg::quad_t timestamp,
    input  logic                 wdog_clear,    // clear timeout flag
    reg_bus_if.target            bus,
    output logic                 wdog_timeout
);
    import board_bus_pkg::*;

    localparam int TICK_W = $clog2(`WDOG_TICK + 1);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`WDOG_TICK - 1);

    quad_t             wdog_period;    // 0 = watchdog disabled
    quad_t             wdog_count;     // ticks since last main write
    logic [TICK_W-1:0] tick_cnt;       // sysclk prescaler
    logic              main_wr;        // any write in main space
    logic              period_wr;      // write to the period register

    assign main_wr   = bus.wen && (bus.waddr.main.space == `ADDR_MAIN);
    assign period_wr = main_wr && (bus.waddr.main.chan == 4'd0)
                       && (bus.waddr.main.offset == `REG_WDOG);

    // ------------------------------------------------------------------
    // watchdog
    // ------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            wdog_period  <= '0;
            wdog_count   <= '0;
            tick_cnt     <= '0;
            wdog_timeout <= 1'b0;
        end else begin
            if (period_wr)
                wdog_period <= bus.wdata;

            // host activity restarts the count
            if (main_wr || wdog_clear) begin
                wdog_count <= '0;
                tick_cnt   <= '0;
            end else if (tick_cnt == TICK_LAST) begin
                tick_cnt <= '0;
                if (wdog_count != wdog_period)
                    wdog_count <= wdog_count + 32'd1;   // holds once it hits the period
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end

            if (wdog_clear || period_wr)
                wdog_timeout <= 1'b0;
            else if ((wdog_period != '0) && (wdog_count == wdog_period))
                wdog_timeout <= 1'b1;                   // sticky until cleared
        end
    end

    // ------------------------------------------------------------------
    // read mux for channel 0 as selected at the top level
    // ------------------------------------------------------------------
    always_comb begin
        case (bus.raddr.main.offset)
            `REG_STATUS:    bus.rdata = {4'd0, board_id, wdog_timeout, 7'd0,
                                         wdog_period[15:0]};
            `REG_TIMESTAMP: bus.rdata = timestamp;
            `REG_WDOG:      bus.rdata = wdog_period;
            default:        bus.rdata = '0;         // undecoded offsets
        endcase
    end

    assign bus.rwait = 1'b0;    // plain register reads

endmodule

/* logic/board_bus_top.sv */
// ----------------------------------------------------------------------
// register bus core with read address translation, space decode, read
// data mux and write bus fan-out to the hub and board registers
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "board_bus_consts.svh"

module board_bus_top #(
    parameter int NUM_MOTORS   = `NUM_MOTORS,
    parameter int NUM_ENCODERS = `NUM_ENCODERS
) (
    input  logic                      sysclk,
    input  logic                      reset,
    input  logic [3:0]                board_id,
    input  board_bus_pkg::reg_addr_t  reg_raddr_in,   // read address from the master
    input  logic                      blk_rt_rd,      // real-time block read active
    input  board_bus_pkg::reg_addr_t  reg_waddr,
    input  board_bus_pkg::quad_t      reg_wdata,
    input  logic                      reg_wen,
    input  board_bus_pkg::quad_t      reg_rdata_ext,  // external board answer
    input  logic                      reg_rwait_ext,
    input  board_bus_pkg::quad_t      timestamp,
    input  logic                      wdog_clear,
    output board_bus_pkg::reg_addr_t  reg_raddr,      // translated address to external board
    output board_bus_pkg::quad_t      reg_rdata,
    output logic                      reg_rwait,
    output logic                      wdog_timeout
);
    import board_bus_pkg::*;

    reg_bus_if hub_bus ();
    reg_bus_if regs_bus ();

    quad_t rdata_sel;       // read data before the output register
    logic  is_hub;          // hub space
    logic  is_chan0;        // main space, board registers

    // ------------------------------------------------------------------
    // read address path
    // ------------------------------------------------------------------
    read_addr_translate #(
        .NUM_MOTORS   (NUM_MOTORS),
        .NUM_ENCODERS (NUM_ENCODERS)
    ) read_addr_translate_inst (
        .reg_raddr_in  (reg_raddr_in),
        .blk_rt_rd     (blk_rt_rd),
        .reg_raddr_out (reg_raddr)
    );

    assign hub_bus.raddr  = reg_raddr;
    assign regs_bus.raddr = reg_raddr;

    // write bus goes to both targets and each checks its own space
    assign hub_bus.waddr  = reg_waddr;
    assign hub_bus.wdata  = reg_wdata;
    assign hub_bus.wen    = reg_wen;
    assign regs_bus.waddr = reg_waddr;
    assign regs_bus.wdata = reg_wdata;
    assign regs_bus.wen   = reg_wen;

    hub_mem hub_mem_inst (
        .sysclk (sysclk),
        .reset  (reset),
        .bus    (hub_bus)
    );

    board_regs board_regs_inst (
        .sysclk       (sysclk),
        .reset        (reset),
        .board_id     (board_id),
        .timestamp    (timestamp),
        .wdog_clear   (wdog_clear),
        .bus          (regs_bus),
        .wdog_timeout (wdog_timeout)
    );

    // ------------------------------------------------------------------
    // space decode and read mux
    // ------------------------------------------------------------------
    assign is_hub   = (reg_raddr.main.space == `ADDR_HUB);
    assign is_chan0 = (reg_raddr.main.space == `ADDR_MAIN) && (reg_raddr.main.chan == 4'd0);

    always_comb begin
        if (is_hub) begin
            rdata_sel = hub_bus.rdata;
            reg_rwait = hub_bus.rwait;      // two-cycle memory read
        end else if (is_chan0) begin
            rdata_sel = regs_bus.rdata;
            reg_rwait = regs_bus.rwait;
        end else begin
            rdata_sel = reg_rdata_ext;      // prom, ethernet and channels land here
            reg_rwait = reg_rwait_ext;
        end
    end

    // valid one sysclk after the address or two when reg_rwait is set
    always_ff @(posedge sysclk) begin
        if (reset)
            reg_rdata <= '0;
        else
            reg_rdata <= rdata_sel;
    end

endmodule

/* test/board_bus_props.sv */
// ----------------------------------------------------------------------
// concurrent checks on the register bus core, bound into the top level
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "board_bus_consts.svh"

module board_bus_props (
    input logic        sysclk,
    input logic        reset,
    input logic        blk_rt_rd,
    input logic [15:0] reg_raddr_in,
    input logic [15:0] reg_raddr,
    input logic        reg_rwait,
    input logic        wdog_timeout
);

    // flag is cleared by every reset cycle
    wdog_low_in_reset: assert property (@(posedge sysclk) reset |=> !wdog_timeout)
        else $error("wdog_timeout high after a reset cycle");

    // no translation outside a real-time block read
    raddr_pass_through: assert property (@(posedge sysclk) disable iff (reset)
        !blk_rt_rd |-> (reg_raddr == reg_raddr_in))
        else $error("reg_raddr differs from reg_raddr_in with blk_rt_rd low");

    // only hub reads take the extra cycle while the external board never waits
    rwait_for_hub: assert property (@(posedge sysclk) disable iff (reset)
        reg_rwait == (reg_raddr[15:12] == `ADDR_HUB))
        else $error("reg_rwait does not match the hub decode");

endmodule

bind board_bus_top board_bus_props board_bus_props_inst (
    .sysclk       (sysclk),
    .reset        (reset),
    .blk_rt_rd    (blk_rt_rd),
    .reg_raddr_in (reg_raddr_in),
    .reg_raddr    (reg_raddr),
    .reg_rwait    (reg_rwait),
    .wdog_timeout (wdog_timeout)
);

/* test/board_bus_tb.sv */
// ----------------------------------------------------------------------
// directed testbench for the register bus core, with an external
// board model, LFSR write data and a cycle limit
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "board_bus_consts.svh"

module board_bus_tb;
    import board_bus_pkg::*;

    localparam int MAX_CYCLES = 2000;   // tests run in under 200 cycles
    localparam int RT_QUADS   = 4 + 2 * `NUM_MOTORS + 5 * `NUM_ENCODERS;

    logic        sysclk;
    logic        reset;
    logic [3:0]  board_id;
    reg_addr_t   reg_raddr_in;
    reg_addr_t   reg_waddr;
    reg_addr_t   reg_raddr;
    logic        blk_rt_rd;
    logic        reg_wen;
    logic        reg_rwait_ext;
    logic        reg_rwait;
    logic        wdog_clear;
    logic        wdog_timeout;
    quad_t       reg_wdata;
    quad_t       reg_rdata_ext;
    quad_t       reg_rdata;
    quad_t       timestamp;
    quad_t       period_exp;        // watchdog period the board should hold
    logic [15:0] lfsr_state;
    int          cycle_count;

    // external board answers with its own address in the low half
    assign reg_rdata_ext = {16'hE000, reg_raddr};
    assign reg_rwait_ext = 1'b0;

    board_bus_top board_bus_top_inst (
        .sysclk        (sysclk),
        .reset         (reset),
        .board_id      (board_id),
        .reg_raddr_in  (reg_raddr_in),
        .blk_rt_rd     (blk_rt_rd),
        .reg_waddr     (reg_waddr),
        .reg_wdata     (reg_wdata),
        .reg_wen       (reg_wen),
        .reg_rdata_ext (reg_rdata_ext),
        .reg_rwait_ext (reg_rwait_ext),
        .timestamp     (timestamp),
        .wdog_clear    (wdog_clear),
        .reg_raddr     (reg_raddr),
        .reg_rdata     (reg_rdata),
        .reg_rwait     (reg_rwait),
        .wdog_timeout  (wdog_timeout)
    );

    initial begin
        sysclk = 1'b0;
        forever #50 sysclk = ~sysclk;   // 100 ns period
    end

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    task automatic next_cycle();
        @(posedge sysclk);
        #10;                            // inputs change 10 ns after the edge
    endtask

    task automatic check(input string name, input quad_t exp, input quad_t act);
        if (exp !== act) begin
            $display("ERROR %s: expected %h actual %h", name, exp, act);
            $display("TB FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // galois lfsr with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 16'hB400;
        return n;
    endfunction

    task automatic rand_word(output quad_t w);
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], lfsr_state[0]};   // one step per bit
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic bus_write(input logic [15:0] addr, input quad_t data);
        reg_waddr = addr;
        reg_wdata = data;
        reg_wen   = 1'b1;
        next_cycle();                   // write lands on this edge
        reg_wen   = 1'b0;
    endtask

    // holds the address for one or two cycles as reg_rwait asks
    task automatic bus_read(input logic [15:0] addr, output quad_t data,
                            output logic wait_flag, output logic [15:0] xaddr);
        reg_raddr_in = addr;
        #1;
        wait_flag = reg_rwait;
        xaddr     = reg_raddr;
        next_cycle();
        if (wait_flag)
            next_cycle();
        data = reg_rdata;
    endtask

    // lets the watchdog run with no writes until the flag rises
    task automatic wait_wdog_timeout(input string name);
        int waited;
        waited = 0;
        while (!wdog_timeout && waited < (period_exp + 1) * `WDOG_TICK) begin
            next_cycle();
            waited++;
        end
        check(name, 32'd1, 32'(wdog_timeout));
    endtask

    function automatic quad_t status_word(input quad_t period, input logic to);
        return {4'd0, board_id, to, 7'd0, period[15:0]};
    endfunction

    // real-time block quadlet to register address
    function automatic logic [15:0] rt_expected(input int q);
        int n;
        n = 0;
        if (q == 0)
            return {`ADDR_MAIN, 8'h00, `REG_STATUS};
        if (q == 1)
            return {`ADDR_MAIN, 8'h00, `REG_TIMESTAMP};
        if (q < 2 + 2 * `NUM_MOTORS) begin
            n = q - 2;
            return {`ADDR_MAIN, 4'h0, 4'(n / 2 + 1), 4'(`RT_MOTOR_REG0 + n % 2)};
        end
        if (q < 2 + 2 * `NUM_MOTORS + 5 * `NUM_ENCODERS) begin
            n = q - 2 - 2 * `NUM_MOTORS;
            return {`ADDR_MAIN, 4'h0, 4'(n / 5 + 1), 4'(`RT_ENC_REG0 + n % 5)};
        end
        return {`ADDR_MAIN, 4'h0, 8'(q)};  // past the table the raw address
    endfunction

    // ------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------
    task automatic test_board_regs();
        quad_t       d;
        logic        w;
        logic [15:0] x;
        timestamp = 32'hC0DE_1234;
        bus_read({`ADDR_MAIN, 8'h00, `REG_STATUS}, d, w, x);
        check("regs status rwait", 32'd0, 32'(w));
        check("regs status", status_word(period_exp, 1'b0), d);
        bus_read({`ADDR_MAIN, 8'h00, `REG_TIMESTAMP}, d, w, x);
        check("regs timestamp rwait", 32'd0, 32'(w));
        check("regs timestamp", timestamp, d);
        period_exp = 32'h0000_8421;     // long enough to stay quiet
        bus_write({`ADDR_MAIN, 8'h00, `REG_WDOG}, period_exp);
        bus_read({`ADDR_MAIN, 8'h00, `REG_WDOG}, d, w, x);
        check("regs wdog period rwait", 32'd0, 32'(w));
        check("regs wdog period", period_exp, d);
        bus_read({`ADDR_MAIN, 8'h00, `REG_STATUS}, d, w, x);
        check("regs status period rwait", 32'd0, 32'(w));
        check("regs status period", status_word(period_exp, 1'b0), d);
    endtask

    task automatic test_hub_mem();
        quad_t       data [6];
        logic [15:0] addr [6];
        quad_t       d;
        logic        w;
        logic [15:0] x;
        for (int i = 0; i < 6; i++) begin
            addr[i] = {`ADDR_HUB, 4'h0, 4'((i * 3) % 16), 4'(15 - 2 * i)};
            rand_word(data[i]);
            bus_write(addr[i], data[i]);
        end
        for (int i = 0; i < 6; i++) begin
            bus_read(addr[i], d, w, x);
            check("hub rwait", 32'd1, 32'(w));
            check("hub data", data[i], d);
        end
    endtask

    task automatic test_external();
        logic [15:0] addr [4] = '{16'h2010, 16'h0123, 16'hF0A5, 16'h40C4};
        quad_t       d;
        logic        w;
        logic [15:0] x;
        for (int i = 0; i < 4; i++) begin
            bus_read(addr[i], d, w, x);
            check("ext raddr", 32'(addr[i]), 32'(x));
            check("ext rwait", 32'd0, 32'(w));
            check("ext data", {16'hE000, addr[i]}, d);
        end
    endtask

    task automatic test_rt_block();
        quad_t       d;
        quad_t       exp;
        logic        w;
        logic [15:0] x;
        blk_rt_rd = 1'b1;
        for (int q = 0; q < RT_QUADS; q++) begin
            bus_read({`ADDR_MAIN, 4'h0, 8'(q)}, d, w, x);
            if (q == 0)
                exp = status_word(period_exp, 1'b0);
            else if (q == 1)
                exp = timestamp;
            else
                exp = {16'hE000, rt_expected(q)};   // channel regs are off board
            check("rt raddr", 32'(rt_expected(q)), 32'(x));
            check("rt rwait", 32'd0, 32'(w));
            check("rt data", exp, d);
        end
        blk_rt_rd = 1'b0;
    endtask

    task automatic test_watchdog();
        quad_t       d;
        logic        w;
        logic [15:0] x;
        period_exp = 32'd3;
        bus_write({`ADDR_MAIN, 8'h00, `REG_WDOG}, period_exp);
        wait_wdog_timeout("wdog timeout set");
        bus_read({`ADDR_MAIN, 8'h00, `REG_STATUS}, d, w, x);
        check("wdog status flag", status_word(period_exp, 1'b1), d);
        // a new period write drops the flag
        bus_write({`ADDR_MAIN, 8'h00, `REG_WDOG}, period_exp);
        check("wdog cleared by period write", 32'd0, 32'(wdog_timeout));
        // keep-alive writes every 8 cycles stay inside 3 ticks
        for (int i = 0; i < 6; i++) begin
            repeat (7) begin
                next_cycle();
                check("wdog kept alive", 32'd0, 32'(wdog_timeout));
            end
            bus_write({`ADDR_MAIN, 8'h10, 4'h0}, 32'(i));
        end
        wait_wdog_timeout("wdog timeout after writes stop");
        wdog_clear = 1'b1;
        next_cycle();
        wdog_clear = 1'b0;
        check("wdog cleared", 32'd0, 32'(wdog_timeout));
    endtask

    // ------------------------------------------------------------------
    // run
    // ------------------------------------------------------------------
    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge sysclk);
            cycle_count++;
        end
        $display("run did not finish within %0d cycles", MAX_CYCLES);
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        reset         = 1'b1;
        board_id      = 4'hA;
        reg_raddr_in  = '0;
        blk_rt_rd     = 1'b0;
        reg_waddr     = '0;
        reg_wdata     = '0;
        reg_wen       = 1'b0;
        timestamp     = '0;
        wdog_clear    = 1'b0;
        period_exp    = '0;
        lfsr_state    = 16'd13;         // seed
        repeat (3) @(posedge sysclk);
        #10;
        reset = 1'b0;
        test_board_regs();
        test_hub_mem();
        test_external();
        test_rt_block();
        test_watchdog();
        $display("TB PASSED");
        $finish;
    end

endmodule

/* src.f */
+incdir+logic
logic/board_bus_pkg.sv
logic/reg_bus_if.sv
logic/read_addr_translate.sv
logic/hub_mem.sv
logic/board_regs.sv
logic/board_bus_top.sv
test/board_bus_props.sv
test/board_bus_tb.sv

/* Makefile */
# Verilator simulation of the register bus core

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module board_bus_tb \
		-f src.f -o board_bus_sim
	./obj_dir/board_bus_sim | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
